/* src.f */
+incdir+.
cp0_pkg.sv
irq_filter.sv
exc_arbiter.sv
cp0_regs.sv
cp0_top.sv
tb_cp0_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the CP0 testbench with Verilator, run it and look for the pass line.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cp0_top -f src.f -o tb_cp0_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_cp0_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

/* tb_cp0_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module tb_cp0_top;

    typedef struct packed {
        logic        w_ena;
        logic [7:0]  w_addr;
        logic [31:0] w_data;
        logic        r_ena;
        logic [7:0]  r_addr;
        logic        commit;
        logic [31:0] pc;
        logic        bd;
        logic [6:0]  flags;        // {adel_if, ri, ov, sys, bp, adel_ld, ades}.
        logic [31:0] bad;
        logic        eret;
        logic [5:0]  irq;
        logic [7:0]  cycles;
        logic [3:0]  chk;          // {int_pending, redirect_pc, flush, r_data}.
        logic [31:0] exp_rdata;
        logic        exp_flush;
        logic [31:0] exp_redir;
        logic        exp_intp;
    } step_t;

    localparam logic [6:0] F_ADEL_IF = 7'b1000000;
    localparam logic [6:0] F_RI      = 7'b0100000;
    localparam logic [6:0] F_OV      = 7'b0010000;
    localparam logic [6:0] F_SYS     = 7'b0001000;
    localparam logic [6:0] F_BP      = 7'b0000100;
    localparam logic [6:0] F_ADEL_LD = 7'b0000010;
    localparam logic [6:0] F_ADES    = 7'b0000001;

    localparam logic [4:0]  CODE_INT   = 5'd0;
    localparam logic [4:0]  CODE_ADEL  = 5'd4;
    localparam logic [4:0]  CODE_ADES  = 5'd5;
    localparam logic [4:0]  CODE_SYS   = 5'd8;
    localparam logic [4:0]  CODE_BP    = 5'd9;
    localparam logic [4:0]  CODE_RI    = 5'd10;
    localparam logic [4:0]  CODE_OV    = 5'd12;
    localparam logic [31:0] TIMER_BASE = 32'h0000_1000;

    logic        clk;
    logic        rst;
    logic [5:0]  irq;
    logic        r_ena;
    logic [7:0]  r_addr;
    logic [31:0] r_data;
    logic        w_ena;
    logic [7:0]  w_addr;
    logic [31:0] w_data;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_bd;
    logic [6:0]  flags_drv;
    logic [31:0] bad_addr;
    logic        eret;
    logic [31:0] epc;
    logic        int_pending;
    logic        flush;
    logic [31:0] redirect_pc;

    step_t       steps[$];
    string       names[$];
    logic [5:0]  irq_level;
    integer      seed;
    int          errors;
    int          passes;
    int          step_fails;
    int          cur_step;
    int          cycle_count;
    int          cycle_limit;

    cp0_top u_cp0_top (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .r_ena        (r_ena),
        .r_addr       (r_addr),
        .r_data       (r_data),
        .w_ena        (w_ena),
        .w_addr       (w_addr),
        .w_data       (w_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_bd    (commit_bd),
        .exc_adel_if  (flags_drv[6]),
        .exc_ri       (flags_drv[5]),
        .exc_ov       (flags_drv[4]),
        .exc_sys      (flags_drv[3]),
        .exc_bp       (flags_drv[2]),
        .exc_adel_ld  (flags_drv[1]),
        .exc_ades     (flags_drv[0]),
        .bad_addr     (bad_addr),
        .eret         (eret),
        .epc          (epc),
        .int_pending  (int_pending),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    // Cause as software sees it: BD, TI, IP7..IP0 and ExcCode.
    function automatic logic [31:0] cause_val(logic bd, logic ti, logic [7:0] ip,
                                              logic [4:0] code);
        cause_val = {bd, ti, 14'd0, ip, 1'b0, code, 2'b00};
    endfunction

    function automatic step_t blank_step();
        step_t s;
        s        = '0;
        s.irq    = irq_level;
        s.cycles = 8'd1;
        s.chk    = 4'b0010;        // flush is compared on every step.
        return s;
    endfunction

    function automatic void add_step(string name, step_t s);
        steps.push_back(s);
        names.push_back(name);
    endfunction

    function automatic void add_read(string name, logic [7:0] addr, logic [31:0] exp);
        step_t s;
        s           = blank_step();
        s.r_ena     = 1'b1;
        s.r_addr    = addr;
        s.chk[0]    = 1'b1;
        s.exp_rdata = exp;
        add_step(name, s);
    endfunction

    function automatic void add_write(string name, logic [7:0] addr, logic [31:0] data,
                                      logic bypass);
        step_t s;
        s        = blank_step();
        s.w_ena  = 1'b1;
        s.w_addr = addr;
        s.w_data = data;
        if (bypass) begin
            s.r_ena     = 1'b1;
            s.r_addr    = addr;
            s.chk[0]    = 1'b1;
            s.exp_rdata = data;    // read of the address under write sees the new word.
        end
        add_step(name, s);
    endfunction

    function automatic void add_idle(string name, logic [5:0] lvl, int cycles);
        step_t s;
        irq_level = lvl;
        s         = blank_step();
        s.cycles  = cycles[7:0];
        add_step(name, s);
    endfunction

    function automatic void add_commit(string name, logic [31:0] pc, logic bd,
                                       logic [6:0] flags, logic [31:0] bad, logic ret,
                                       logic [31:0] redir);
        step_t s;
        s           = blank_step();
        s.commit    = 1'b1;
        s.pc        = pc;
        s.bd        = bd;
        s.flags     = flags;
        s.bad       = bad;
        s.eret      = ret;
        s.chk[2]    = 1'b1;
        s.exp_flush = 1'b1;
        s.exp_redir = redir;
        add_step(name, s);
    endfunction

    function automatic void expect_intp(logic v);
        step_t s;
        s          = steps.pop_back();
        s.chk[3]   = 1'b1;
        s.exp_intp = v;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] pc_c;
        logic [31:0] pc_d;
        logic [31:0] pc_e;
        logic [31:0] pc_f;
        logic [31:0] bad_a;
        logic [31:0] bad_b;
        pc_a  = $random(seed) & 32'hffff_fffc;
        pc_b  = $random(seed) & 32'hffff_fffc;
        pc_c  = $random(seed) & 32'hffff_fffc;
        pc_d  = $random(seed) & 32'hffff_fffc;
        pc_e  = $random(seed) & 32'hffff_fffc;
        pc_f  = $random(seed) & 32'hffff_fffc;
        bad_a = $random(seed);
        bad_b = $random(seed);
        irq_level = 6'd0;

        add_read("status_rst", `CP0_STATUS, 32'h0040_0000);
        add_read("cause_rst", `CP0_CAUSE, 32'd0);
        add_write("compare_zero", `CP0_COMPARE, 32'd0, 1'b0);
        add_write("status_ones", `CP0_STATUS, 32'hffff_ffff, 1'b1);
        add_read("status_mask", `CP0_STATUS, 32'h0040_ff03);
        add_write("cause_ones", `CP0_CAUSE, 32'hffff_ffff, 1'b1);
        add_read("cause_mask", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h03, CODE_INT));
        add_write("status_zero", `CP0_STATUS, 32'd0, 1'b0);
        add_write("cause_zero", `CP0_CAUSE, 32'd0, 1'b0);
        add_read("status_clean", `CP0_STATUS, 32'h0040_0000);
        add_read("cause_clean", `CP0_CAUSE, 32'd0);

        add_write("count_set", `CP0_COUNT, TIMER_BASE, 1'b0);
        add_idle("count_run", 6'd0, 3);
        add_read("count_read", `CP0_COUNT, TIMER_BASE + 32'd3);   // one tick per idle cycle.
        add_write("compare_set", `CP0_COMPARE, TIMER_BASE + 32'd5, 1'b0);
        add_read("ti_early", `CP0_CAUSE, 32'd0);
        add_idle("ti_wait", 6'd0, 2);
        add_read("ti_set", `CP0_CAUSE, cause_val(1'b0, 1'b1, 8'h80, CODE_INT));
        add_write("compare_clr", `CP0_COMPARE, 32'd0, 1'b0);
        add_idle("ti_drain", 6'd0, 1);
        add_read("ti_clear", `CP0_CAUSE, 32'd0);

        add_commit("exc_ri", pc_a, 1'b0, F_RI | F_OV | F_SYS | F_BP, bad_a, 1'b0, `EXC_VECTOR);
        add_read("cause_ri", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h00, CODE_RI));
        add_read("epc_ri", `CP0_EPC, pc_a);
        add_write("exl_clr_1", `CP0_STATUS, 32'd0, 1'b0);
        add_commit("exc_adel_if", pc_b, 1'b1, F_ADEL_IF | F_RI | F_ADES, bad_a, 1'b0,
                   `EXC_VECTOR);
        add_read("cause_adel_if", `CP0_CAUSE, cause_val(1'b1, 1'b0, 8'h00, CODE_ADEL));
        add_read("epc_slot", `CP0_EPC, pc_b - 32'd4);
        add_read("bva_fetch", `CP0_BADVADDR, pc_b);
        add_write("bva_sw_write", `CP0_BADVADDR, 32'h1234_5678, 1'b0);
        add_read("bva_kept", `CP0_BADVADDR, pc_b);
        add_write("exl_clr_2", `CP0_STATUS, 32'd0, 1'b0);
        add_commit("exc_ov", pc_c, 1'b0, F_OV | F_SYS | F_ADEL_LD | F_ADES, bad_a, 1'b0,
                   `EXC_VECTOR);
        add_read("cause_ov", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h00, CODE_OV));
        add_write("exl_clr_3", `CP0_STATUS, 32'd0, 1'b0);
        add_commit("exc_adel_ld", pc_c, 1'b0, F_ADEL_LD | F_ADES, bad_a, 1'b0, `EXC_VECTOR);
        add_read("cause_adel_ld", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h00, CODE_ADEL));
        add_read("bva_load", `CP0_BADVADDR, bad_a);
        add_write("exl_clr_4", `CP0_STATUS, 32'd0, 1'b0);
        add_commit("exc_ades", pc_d, 1'b0, F_ADES, bad_b, 1'b0, `EXC_VECTOR);
        add_read("cause_ades", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h00, CODE_ADES));
        add_read("bva_store", `CP0_BADVADDR, bad_b);
        add_write("exl_clr_5", `CP0_STATUS, 32'd0, 1'b0);
        add_commit("exc_bp", pc_d, 1'b0, F_BP | F_ADEL_LD | F_ADES, bad_a, 1'b0, `EXC_VECTOR);
        add_read("cause_bp", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h00, CODE_BP));
        add_read("bva_bp_kept", `CP0_BADVADDR, bad_b);
        add_write("exl_clr_6", `CP0_STATUS, 32'd0, 1'b0);

        add_commit("exc_sys", pc_e, 1'b0, F_SYS | F_BP, bad_b, 1'b0, `EXC_VECTOR);
        add_commit("exc_nested", pc_f, 1'b1, F_BP, bad_b, 1'b0, `EXC_VECTOR);
        add_read("epc_kept", `CP0_EPC, pc_e);
        add_read("cause_kept", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h00, CODE_SYS));
        add_commit("eret", pc_f, 1'b0, 7'd0, bad_b, 1'b1, pc_e);
        add_read("exl_off", `CP0_STATUS, 32'h0040_0000);

        add_write("im2_ie", `CP0_STATUS, 32'h0000_0401, 1'b0);
        add_idle("irq_glitch", 6'b000001, 2);
        add_idle("irq_quiet", 6'd0, 10);
        add_read("ip_none", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h00, CODE_SYS));
        expect_intp(1'b0);
        // first sample plus 3 + STABLE_CYCLES before int_pending rises.
        add_idle("irq_hold", 6'b000001, 3 + `IRQ_STABLE_DEFAULT);
        add_idle("irq_edge", 6'b000001, 1);
        expect_intp(1'b0);
        add_commit("exc_int", pc_a, 1'b0, F_ADEL_IF | F_RI, bad_b, 1'b0, `EXC_VECTOR);
        expect_intp(1'b1);
        add_read("cause_int", `CP0_CAUSE, cause_val(1'b0, 1'b0, 8'h04, CODE_INT));
        expect_intp(1'b0);
        add_idle("irq_release", 6'd0, 1);
        add_read("epc_int", `CP0_EPC, pc_a);
    endfunction

    task automatic drive_step(step_t s);
        w_ena        = s.w_ena;
        w_addr       = s.w_addr;
        w_data       = s.w_data;
        r_ena        = s.r_ena;
        r_addr       = s.r_addr;
        commit_valid = s.commit;
        commit_pc    = s.pc;
        commit_bd    = s.bd;
        flags_drv    = s.flags;
        bad_addr     = s.bad;
        eret         = s.eret;
        irq          = s.irq;
    endtask

    task automatic clear_strobes();
        w_ena        = 1'b0;
        r_ena        = 1'b0;
        commit_valid = 1'b0;
        flags_drv    = 7'd0;
        eret         = 1'b0;
    endtask

    task automatic check_value(string sig, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) begin
            passes++;
        end else begin
            $display("[FAIL] step %0d %s: got %h, expected %h", cur_step, sig, got, exp);
            errors++;
            step_fails++;
        end
    endtask

    initial begin
        step_t s;
        int    total;
        seed         = 32'h18d18704;
        rst          = 1'b1;
        irq          = 6'd0;
        r_addr       = 8'd0;
        w_addr       = 8'd0;
        w_data       = 32'd0;
        commit_pc    = 32'd0;
        commit_bd    = 1'b0;
        bad_addr     = 32'd0;
        errors       = 0;
        passes       = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        clear_strobes();

        build_table();
        total = 0;
        foreach (steps[i]) total += int'(steps[i].cycles);
        cycle_limit = 2 * total;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            s          = steps[i];
            cur_step   = i;
            step_fails = 0;
            drive_step(s);
            #1;
            if (s.chk[0]) check_value("r_data", r_data, s.exp_rdata);
            if (s.chk[0] && (s.r_addr == `CP0_EPC) && !s.w_ena) begin
                check_value("epc", epc, s.exp_rdata);    // port follows the register.
            end
            if (s.chk[1]) check_value("flush", {31'd0, flush}, {31'd0, s.exp_flush});
            if (s.chk[2]) check_value("redirect_pc", redirect_pc, s.exp_redir);
            if (s.chk[3]) check_value("int_pending", {31'd0, int_pending}, {31'd0, s.exp_intp});
            $display("step %0d %s: %s", i, names[i], (step_fails == 0) ? "ok" : "mismatch");
            repeat (int'(s.cycles)) begin
                @(posedge clk);
                @(negedge clk);
                clear_strobes();
            end
        end

        $display("%0d steps, %0d checks passed, %0d checks failed", steps.size(), passes, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cp0_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_top (
    input  logic               clk,
    input  logic               rst,
    input  logic [5:0]         irq,
    input  logic               r_ena,
    input  cp0_pkg::cp0_addr_t r_addr,
    output cp0_pkg::word_t     r_data,
    input  logic               w_ena,
    input  cp0_pkg::cp0_addr_t w_addr,
    input  cp0_pkg::word_t     w_data,
    input  logic               commit_valid,
    input  cp0_pkg::word_t     commit_pc,
    input  logic               commit_bd,
    input  logic               exc_adel_if,
    input  logic               exc_ri,
    input  logic               exc_ov,
    input  logic               exc_sys,
    input  logic               exc_bp,
    input  logic               exc_adel_ld,
    input  logic               exc_ades,
    input  cp0_pkg::word_t     bad_addr,
    input  logic               eret,
    output cp0_pkg::word_t     epc,
    output logic               int_pending,
    output logic               flush,
    output cp0_pkg::word_t     redirect_pc
);

    logic [`IRQ_LINES-1:0] irq_clean;
    logic                  update_ena;
    logic                  bd;
    logic                  badvaddr_ena;
    logic                  cls_exl;
    logic                  exl;
    cp0_pkg::exccode_t     exccode;
    cp0_pkg::word_t        epc_upd;
    cp0_pkg::word_t        badvaddr;

    // one debouncer per pin.
    for (genvar i = 0; i < `IRQ_LINES; i++) begin : g_irq
        irq_filter #(
            .STABLE_CYCLES (`IRQ_STABLE_DEFAULT)
        ) u_irq_filter (
            .clk       (clk),
            .rst       (rst),
            .irq_raw   (irq[i]),
            .irq_clean (irq_clean[i])
        );
    end

    exc_arbiter u_exc_arbiter (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_bd    (commit_bd),
        .commit_pc    (commit_pc),
        .bad_addr     (bad_addr),
        .exc_adel_if  (exc_adel_if),
        .exc_ri       (exc_ri),
        .exc_ov       (exc_ov),
        .exc_sys      (exc_sys),
        .exc_bp       (exc_bp),
        .exc_adel_ld  (exc_adel_ld),
        .exc_ades     (exc_ades),
        .eret         (eret),
        .int_pending  (int_pending),
        .exl          (exl),
        .epc_in       (epc),
        .update_ena   (update_ena),
        .bd           (bd),
        .badvaddr_ena (badvaddr_ena),
        .cls_exl      (cls_exl),
        .flush        (flush),
        .exccode      (exccode),
        .epc          (epc_upd),
        .badvaddr     (badvaddr),
        .redirect_pc  (redirect_pc)
    );

    cp0_regs u_cp0_regs (
        .clk          (clk),
        .rst          (rst),
        .irq_clean    (irq_clean),
        .r_ena        (r_ena),
        .w_ena        (w_ena),
        .r_addr       (r_addr),
        .w_addr       (w_addr),
        .w_data       (w_data),
        .r_data       (r_data),
        .update_ena   (update_ena),
        .bd           (bd),
        .badvaddr_ena (badvaddr_ena),
        .cls_exl      (cls_exl),
        .exccode      (exccode),
        .epc_upd      (epc_upd),
        .badvaddr     (badvaddr),
        .epc          (epc),
        .exl          (exl),
        .int_pending  (int_pending)
    );

endmodule

`default_nettype wire

/* cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic [5:0]          irq_clean,
    input  logic                r_ena,
    input  logic                w_ena,
    input  cp0_pkg::cp0_addr_t  r_addr,
    input  cp0_pkg::cp0_addr_t  w_addr,
    input  cp0_pkg::word_t      w_data,
    output cp0_pkg::word_t      r_data,
    input  logic                update_ena,
    input  logic                bd,
    input  logic                badvaddr_ena,
    input  logic                cls_exl,
    input  cp0_pkg::exccode_t   exccode,
    input  cp0_pkg::word_t      epc_upd,
    input  cp0_pkg::word_t      badvaddr,
    output cp0_pkg::word_t      epc,
    output logic                exl,
    output logic                int_pending
);

    localparam cp0_pkg::word_t STATUS_RST  = 32'h0040_0000;  // BEV only.
    localparam cp0_pkg::word_t STATUS_LIVE = 32'h0040_ff03;  // BEV, IM, EXL, IE.

    cp0_pkg::word_t badvaddr_reg;
    cp0_pkg::word_t count;
    cp0_pkg::word_t compare;
    cp0_pkg::word_t status;
    cp0_pkg::word_t cause;
    cp0_pkg::word_t epc_reg;

    logic wr_count;
    logic wr_compare;
    logic wr_status;
    logic wr_cause;
    logic wr_epc;
    logic timer_hit;

    assign wr_count   = w_ena && (w_addr == `CP0_COUNT);
    assign wr_compare = w_ena && (w_addr == `CP0_COMPARE);
    assign wr_status  = w_ena && (w_addr == `CP0_STATUS);
    assign wr_cause   = w_ena && (w_addr == `CP0_CAUSE);
    assign wr_epc     = w_ena && (w_addr == `CP0_EPC);

    assign timer_hit = (compare != 32'd0) && (count == compare);

    // timer and address registers, no reset.
    always_ff @(posedge clk) begin
        if (wr_count) begin
            count <= w_data;
        end else begin
            count <= count + 32'd1;    // free running, also in reset.
        end

        if (wr_compare) begin
            compare <= w_data;
        end

        if (update_ena) begin
            epc_reg <= epc_upd;
        end else if (wr_epc) begin
            epc_reg <= w_data;
        end

        if (update_ena && badvaddr_ena) begin
            badvaddr_reg <= badvaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= STATUS_RST;
            cause  <= '0;
        end else begin
            if (wr_status) begin
                status[15:8] <= w_data[15:8];
                status[1]    <= w_data[1];
                status[0]    <= w_data[0];
            end
            if (wr_cause) begin
                cause[9:8] <= w_data[9:8];     // software interrupts only.
            end

            if (timer_hit) begin
                cause[30] <= 1'b1;
            end
            if (wr_compare) begin
                cause[30] <= 1'b0;             // acknowledge the timer.
            end

            if (cls_exl) begin
                status[1] <= 1'b0;
            end
            if (update_ena) begin
                status[1]  <= 1'b1;            // wins over a software write.
                cause[31]  <= bd;
                cause[6:2] <= exccode;
            end
        end

        // hardware lines are sampled every cycle, reset or not.
        cause[15:10] <= {cause[30] | irq_clean[5], irq_clean[4:0]};
    end

    assign epc         = epc_reg;
    assign exl         = status[1];
    assign int_pending = status[0] & ~status[1] & (|(status[15:8] & cause[15:8]));

    always_comb begin
        r_data = '0;
        if (!rst && r_ena) begin
            if (w_ena && (w_addr == r_addr)) begin
                r_data = w_data;               // same-cycle write bypass.
            end else begin
                case (r_addr)
                    `CP0_BADVADDR: r_data = badvaddr_reg;
                    `CP0_COUNT:    r_data = count;
                    `CP0_COMPARE:  r_data = compare;
                    `CP0_STATUS:   r_data = status;
                    `CP0_CAUSE:    r_data = cause;
                    `CP0_EPC:      r_data = epc_reg;
                    default:       r_data = '0;
                endcase
            end
        end
    end

    a_status_reserved: assert property (
        @(posedge clk) disable iff (rst)
        (status & ~STATUS_LIVE) == 32'd0
    );

endmodule

`default_nettype wire

/* exc_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module exc_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              commit_valid,
    input  logic              commit_bd,
    input  cp0_pkg::word_t    commit_pc,
    input  cp0_pkg::word_t    bad_addr,
    input  logic              exc_adel_if,
    input  logic              exc_ri,
    input  logic              exc_ov,
    input  logic              exc_sys,
    input  logic              exc_bp,
    input  logic              exc_adel_ld,
    input  logic              exc_ades,
    input  logic              eret,
    input  logic              int_pending,
    input  logic              exl,
    input  cp0_pkg::word_t    epc_in,
    output logic              update_ena,
    output logic              bd,
    output logic              badvaddr_ena,
    output logic              cls_exl,
    output logic              flush,
    output cp0_pkg::exccode_t exccode,
    output cp0_pkg::word_t    epc,
    output cp0_pkg::word_t    badvaddr,
    output cp0_pkg::word_t    redirect_pc
);

    logic              exc_any;
    logic              bva_sel;
    cp0_pkg::exccode_t code_sel;
    cp0_pkg::word_t    bva_val;

    // fixed priority, highest first.
    always_comb begin
        exc_any  = commit_valid;
        code_sel = cp0_pkg::INT;
        bva_sel  = 1'b0;
        bva_val  = bad_addr;
        if (int_pending) begin
            code_sel = cp0_pkg::INT;
        end else if (exc_adel_if) begin
            code_sel = cp0_pkg::ADEL;
            bva_sel  = 1'b1;
            bva_val  = commit_pc;      // fetch faults report the pc itself.
        end else if (exc_ri) begin
            code_sel = cp0_pkg::RI;
        end else if (exc_ov) begin
            code_sel = cp0_pkg::OV;
        end else if (exc_sys) begin
            code_sel = cp0_pkg::SYS;
        end else if (exc_bp) begin
            code_sel = cp0_pkg::BP;
        end else if (exc_adel_ld) begin
            code_sel = cp0_pkg::ADEL;
            bva_sel  = 1'b1;
        end else if (exc_ades) begin
            code_sel = cp0_pkg::ADES;
            bva_sel  = 1'b1;
        end else begin
            exc_any = 1'b0;
        end
    end

    // nested exceptions keep the first EPC/Cause.
    assign update_ena   = exc_any & ~exl;
    assign exccode      = code_sel;
    assign bd           = commit_bd;
    assign epc          = commit_bd ? commit_pc - 32'd4 : commit_pc;  // restart at the branch.
    assign badvaddr_ena = update_ena & bva_sel;
    assign badvaddr     = bva_val;

    assign cls_exl     = commit_valid & eret & ~exc_any;
    assign flush       = exc_any | cls_exl;
    assign redirect_pc = exc_any ? `EXC_VECTOR : epc_in;

    a_set_clr_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(update_ena && cls_exl)
    );

    a_update_commit: assert property (
        @(posedge clk) disable iff (rst)
        update_ena |-> commit_valid
    );

endmodule

`default_nettype wire

/* irq_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module irq_filter #(
    parameter int STABLE_CYCLES = `IRQ_STABLE_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    input  logic irq_raw,
    output logic irq_clean
);

    localparam int               CNT_W   = $clog2(STABLE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(STABLE_CYCLES);

    logic             sync_q1;
    logic             sync_q2;
    logic             differ;
    logic [CNT_W-1:0] cnt;

    assign differ = sync_q2 ^ irq_clean;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1   <= 1'b0;
            sync_q2   <= 1'b0;
            cnt       <= '0;
            irq_clean <= 1'b0;
        end else begin
            sync_q1 <= irq_raw;
            sync_q2 <= sync_q1;
            if (!differ) begin
                cnt <= '0;                 // any agreement restarts the count.
            end else if (cnt == CNT_MAX) begin
                irq_clean <= sync_q2;
                cnt       <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // the clean level only moves once the counter has run out.
    a_flip_at_limit: assert property (
        @(posedge clk) disable iff (rst)
        $changed(irq_clean) |-> $past(cnt) == CNT_MAX
    );

endmodule

`default_nettype wire

/* cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    typedef logic [31:0] word_t;

    // cp0 address as seen by mfc0/mtc0.
    typedef struct packed {
        logic [4:0] reg_num;
        logic [2:0] sel;
    } cp0_addr_t;

    // Cause.ExcCode values handled by this core.
    typedef enum logic [4:0] {
        INT  = 5'd0,   // interrupt.
        ADEL = 5'd4,   // address error, fetch or load.
        ADES = 5'd5,   // address error, store.
        SYS  = 5'd8,   // syscall.
        BP   = 5'd9,   // break.
        RI   = 5'd10,  // reserved instruction.
        OV   = 5'd12   // arithmetic overflow.
    } exccode_t;

endpackage

`default_nettype wire

/* cp0_defs.svh */
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// cp0 register addresses, {reg_num, sel} with sel = 0.
`define CP0_BADVADDR 8'h40
`define CP0_COUNT    8'h48
`define CP0_COMPARE  8'h58
`define CP0_STATUS   8'h60
`define CP0_CAUSE    8'h68
`define CP0_EPC      8'h70

// general exception entry while BEV is set.
`define EXC_VECTOR 32'hbfc00380

// external interrupt lines, mapped onto Cause.IP7..IP2.
`define IRQ_LINES 6

// cycles an irq level must hold before it is accepted.
`define IRQ_STABLE_DEFAULT 4

`endif
